// ==== vec_issue_ctrl.f ====
+incdir+.
vec_pkg.sv
vec_op_queue.sv
vec_op_decode.sv
vec_scoreboard.sv
vec_unit_pipe.sv
vec_wb_arbiter.sv
vec_issue_ctrl.sv
tb_vec_issue_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the issue controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vec_issue_ctrl.f \
  --top-module tb_vec_issue_ctrl -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// ==== tb_vec_issue_ctrl.sv ====
// self-checking testbench for the vector issue controller, run as the simulation top
`timescale 1ns/1ps
`include "vec_defines.svh"

module tb_vec_issue_ctrl import vec_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 200;
  localparam int HAZARD_LEN     = 12;
  localparam int CHAIN_LEN      = 10;
  localparam int RANDOM_LEN     = 40;

  typedef struct packed {
    vec_opcode_e op;
    vec_reg_t    rt;
    vec_reg_t    ra;
    vec_reg_t    rb;
    vec_unit_e   unit;
    logic        we;
  } stim_t;

  logic        clk;
  logic        reset;
  logic        inst_valid;
  vec_opcode_e inst_opcode;
  vec_reg_t    inst_rt;
  vec_reg_t    inst_ra;
  vec_reg_t    inst_rb;
  logic        ready;
  logic        pipe_empty;
  logic        wb_en;
  logic        wb_we;
  vec_reg_t    wb_addr;
  vec_unit_e   wb_unit;

  // expected class of the instruction currently on the inputs
  vec_unit_e   drv_unit;
  logic        drv_we;

  stim_t       hazard_table [HAZARD_LEN];
  logic [31:0] lfsr;

  // reference model, updated only by the monitor
  vec_unit_e   write_fifo [`VEC_NUM_REGS][$];
  int          mac_pending [`VEC_NUM_REGS];
  int          unit_outstanding [2];
  int          accepted;
  int          written_back;
  int          stall_cycles;
  int          mon_checks;
  int          mon_errors;
  int          seq_checks;
  int          seq_errors;

  vec_issue_ctrl u_dut (
    .clk         (clk),
    .reset       (reset),
    .inst_valid  (inst_valid),
    .inst_opcode (inst_opcode),
    .inst_rt     (inst_rt),
    .inst_ra     (inst_ra),
    .inst_rb     (inst_rb),
    .ready       (ready),
    .pipe_empty  (pipe_empty),
    .wb_en       (wb_en),
    .wb_we       (wb_we),
    .wb_addr     (wb_addr),
    .wb_unit     (wb_unit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------
  // opcode rules and stimulus helpers
  // ----------------------------------------
  function automatic vec_unit_e unit_for(input vec_opcode_e op);
    if (op == op_splat || op == op_shift || op == op_sel) begin
      return unit_permute;
    end
    return unit_madd;
  endfunction

  // mac accumulates inside the unit
  function automatic logic writes_rt(input vec_opcode_e op);
    return (op != op_mac);
  endfunction

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic        fb;
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s at %0t", TIMEOUT_CYCLES, what, $time);
    $display("checks %0d, errors %0d", seq_checks + mon_checks, seq_errors + mon_errors);
    $display("TEST FAILED");
    $finish;
  endtask

  // called at a rising edge, returns at the edge that accepts the entry
  task automatic send_inst(input stim_t s);
    int waited;
    waited = 0;
    inst_valid  <= 1'b1;
    inst_opcode <= s.op;
    inst_rt     <= s.rt;
    inst_ra     <= s.ra;
    inst_rb     <= s.rb;
    drv_unit    <= s.unit;
    drv_we      <= s.we;
    @(negedge clk);
    while (!ready && waited < TIMEOUT_CYCLES) begin
      waited++;
      @(negedge clk);
    end
    if (!ready) begin
      abort_on_timeout("ready");
    end
    @(posedge clk);
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(pipe_empty && accepted == written_back) && waited < TIMEOUT_CYCLES) begin
      waited++;
      @(negedge clk);
    end
    if (!(pipe_empty && accepted == written_back)) begin
      abort_on_timeout(what);
    end
    @(posedge clk);
  endtask

  // ----------------------------------------
  // monitor and reference model
  // ----------------------------------------
  always @(negedge clk) begin
    if (!reset) begin
      if (inst_valid && !ready) begin
        stall_cycles++;
      end
      if (inst_valid && ready) begin
        accepted++;
        unit_outstanding[drv_unit]++;
        if (drv_we) begin
          write_fifo[inst_rt].push_back(drv_unit);
        end else begin
          mac_pending[inst_rt]++;
        end
      end
      if (wb_en) begin
        written_back++;
        mon_checks++;
        assert (unit_outstanding[wb_unit] > 0)
          else begin
            $display("Error %0t: writeback from %s with nothing outstanding",
                     $time, wb_unit.name());
            mon_errors++;
          end
        if (unit_outstanding[wb_unit] > 0) begin
          unit_outstanding[wb_unit]--;
        end
        mon_checks++;
        if (wb_we) begin
          // oldest write to this register must come first
          assert (write_fifo[wb_addr].size() > 0 && write_fifo[wb_addr][0] == wb_unit)
            else begin
              $display("Error %0t: write to r%0d from %s out of program order",
                       $time, wb_addr, wb_unit.name());
              mon_errors++;
            end
          if (write_fifo[wb_addr].size() > 0) begin
            void'(write_fifo[wb_addr].pop_front());
          end
        end else begin
          assert (mac_pending[wb_addr] > 0 && wb_unit == unit_madd)
            else begin
              $display("Error %0t: unexpected no-write writeback r%0d from %s",
                       $time, wb_addr, wb_unit.name());
              mon_errors++;
            end
          if (mac_pending[wb_addr] > 0) begin
            mac_pending[wb_addr]--;
          end
        end
      end
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    stim_t       entry;
    vec_opcode_e op;
    logic [31:0] bits;
    int          stalls_before;
    int          leftover;
    reset       <= 1'b1;
    inst_valid  <= 1'b0;
    inst_opcode <= op_add;
    inst_rt     <= '0;
    inst_ra     <= '0;
    inst_rb     <= '0;
    drv_unit    <= unit_madd;
    drv_we      <= 1'b0;
    lfsr = 32'hd274;
    hazard_table = '{
      '{op_add,   5'd1,  5'd2, 5'd3, unit_madd,    1'b1},
      // RAW and WAW on r1 behind the add
      '{op_add,   5'd1,  5'd1, 5'd4, unit_madd,    1'b1},
      '{op_splat, 5'd1,  5'd0, 5'd0, unit_permute, 1'b1},
      '{op_shift, 5'd5,  5'd1, 5'd0, unit_permute, 1'b1},
      '{op_mac,   5'd1,  5'd5, 5'd6, unit_madd,    1'b0},
      '{op_sel,   5'd7,  5'd5, 5'd1, unit_permute, 1'b1},
      '{op_mul,   5'd8,  5'd7, 5'd7, unit_madd,    1'b1},
      '{op_mul,   5'd8,  5'd8, 5'd8, unit_madd,    1'b1},
      // back-to-back writes to one register
      '{op_splat, 5'd9,  5'd0, 5'd0, unit_permute, 1'b1},
      '{op_splat, 5'd9,  5'd0, 5'd0, unit_permute, 1'b1},
      '{op_mac,   5'd0,  5'd0, 5'd0, unit_madd,    1'b0},
      '{op_shift, 5'd10, 5'd9, 5'd0, unit_permute, 1'b1}
    };
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    seq_checks++;
    assert (ready && pipe_empty && !wb_en && !wb_we)
      else begin
        $display("Error %0t: after reset ready %0b pipe_empty %0b wb_en %0b wb_we %0b",
                 $time, ready, pipe_empty, wb_en, wb_we);
        seq_errors++;
      end
    @(posedge clk);

    for (int i = 0; i < HAZARD_LEN; i++) begin
      send_inst(hazard_table[i]);
    end
    inst_valid <= 1'b0;
    wait_drain("the hazard table to drain");

    // dependent multiply chain with valid held high
    stalls_before = stall_cycles;
    for (int i = 0; i < CHAIN_LEN; i++) begin
      send_inst('{op_mul, 5'd2, 5'd2, 5'd2, unit_madd, 1'b1});
    end
    inst_valid <= 1'b0;
    wait_drain("the dependent chain to drain");
    seq_checks++;
    assert (stall_cycles > stalls_before)
      else begin
        $display("Error %0t: ready never fell during the dependent chain", $time);
        seq_errors++;
      end

    // random mix on eight registers for frequent hazards
    for (int i = 0; i < RANDOM_LEN; i++) begin
      bits = take_bits(3);
      op = vec_opcode_e'(bits[2:0] % 3'd6);
      entry.op   = op;
      entry.unit = unit_for(op);
      entry.we   = writes_rt(op);
      bits = take_bits(3);
      entry.rt = vec_reg_t'(bits);
      bits = take_bits(3);
      entry.ra = vec_reg_t'(bits);
      bits = take_bits(3);
      entry.rb = vec_reg_t'(bits);
      send_inst(entry);
      bits = take_bits(1);
      if (bits[0]) begin
        inst_valid <= 1'b0;
        @(posedge clk);
      end
    end
    inst_valid <= 1'b0;
    wait_drain("pipe_empty after random traffic");

    leftover = 0;
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
      leftover += write_fifo[r].size() + mac_pending[r];
    end
    seq_checks++;
    assert (accepted == written_back && leftover == 0)
      else begin
        $display("Error %0t: accepted %0d, writebacks %0d, %0d expected writebacks left",
                 $time, accepted, written_back, leftover);
        seq_errors++;
      end

    $display("checks %0d, errors %0d, accepted %0d, writebacks %0d",
             seq_checks + mon_checks, seq_errors + mon_errors, accepted, written_back);
    if (seq_errors + mon_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== vec_issue_ctrl.sv ====
// top level of the vector issue controller: decode, queue, scoreboard, unit pipes, writeback
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_issue_ctrl import vec_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        inst_valid,
  input  vec_opcode_e inst_opcode,
  input  vec_reg_t    inst_rt,
  input  vec_reg_t    inst_ra,
  input  vec_reg_t    inst_rb,
  output logic        ready,
  output logic        pipe_empty,
  output logic        wb_en,
  output logic        wb_we,
  output vec_reg_t    wb_addr,
  output vec_unit_e   wb_unit
);

  logic      inst_accept;
  logic      dec_push;
  logic      dec_busy;
  vec_unit_e dec_unit;
  logic      dec_read_ra;
  logic      dec_read_rb;
  logic      dec_write_rt;
  vec_reg_t  dec_rt;
  vec_reg_t  dec_ra;
  vec_reg_t  dec_rb;
  logic      q_full;
  logic      q_almost_full;
  logic      head_valid;
  vec_unit_e head_unit;
  logic      head_read_ra;
  logic      head_read_rb;
  logic      head_write_rt;
  vec_reg_t  head_rt;
  vec_reg_t  head_ra;
  vec_reg_t  head_rb;
  logic      q_pop;
  logic      issue_madd;
  logic      issue_permute;
  logic      sb_idle;
  logic      madd_in_ready;
  logic      madd_req;
  logic      madd_we;
  vec_reg_t  madd_rt;
  logic      madd_grant;
  logic      madd_empty;
  logic      permute_in_ready;
  logic      permute_req;
  logic      permute_we;
  vec_reg_t  permute_rt;
  logic      permute_grant;
  logic      permute_empty;

  // ----------------------------------------
  // front end
  // ----------------------------------------
  assign ready       = !q_almost_full && !q_full;
  assign inst_accept = inst_valid && ready;

  vec_op_decode u_decode (
    .clk, .reset,
    .inst_valid (inst_accept),
    .inst_opcode, .inst_rt, .inst_ra, .inst_rb,
    .q_full,
    .push       (dec_push),
    .op_unit    (dec_unit),
    .op_read_ra (dec_read_ra),
    .op_read_rb (dec_read_rb),
    .op_write_rt(dec_write_rt),
    .op_rt      (dec_rt),
    .op_ra      (dec_ra),
    .op_rb      (dec_rb),
    .busy       (dec_busy)
  );

  vec_op_queue u_queue (
    .clk, .reset,
    .push       (dec_push),
    .pop        (q_pop),
    .in_unit    (dec_unit),
    .in_read_ra (dec_read_ra),
    .in_read_rb (dec_read_rb),
    .in_write_rt(dec_write_rt),
    .in_rt      (dec_rt),
    .in_ra      (dec_ra),
    .in_rb      (dec_rb),
    .head_valid,
    .full       (q_full),
    .almost_full(q_almost_full),
    .head_unit, .head_read_ra, .head_read_rb, .head_write_rt,
    .head_rt, .head_ra, .head_rb
  );

  vec_scoreboard u_scoreboard (
    .clk, .reset,
    .head_valid, .head_unit, .head_read_ra, .head_read_rb, .head_write_rt,
    .head_rt, .head_ra, .head_rb,
    .madd_in_ready, .permute_in_ready,
    .wb_en, .wb_we, .wb_addr,
    .pop        (q_pop),
    .issue_madd, .issue_permute,
    .idle       (sb_idle)
  );

  // ----------------------------------------
  // execution units and writeback
  // ----------------------------------------
  vec_unit_pipe #(.LATENCY(`VEC_MADD_LATENCY)) u_madd_pipe (
    .clk, .reset,
    .issue   (issue_madd),
    .issue_rt(head_rt),
    .issue_we(head_write_rt),
    .grant   (madd_grant),
    .in_ready(madd_in_ready),
    .req     (madd_req),
    .req_rt  (madd_rt),
    .req_we  (madd_we),
    .empty   (madd_empty)
  );

  vec_unit_pipe #(.LATENCY(`VEC_PERMUTE_LATENCY)) u_permute_pipe (
    .clk, .reset,
    .issue   (issue_permute),
    .issue_rt(head_rt),
    .issue_we(head_write_rt),
    .grant   (permute_grant),
    .in_ready(permute_in_ready),
    .req     (permute_req),
    .req_rt  (permute_rt),
    .req_we  (permute_we),
    .empty   (permute_empty)
  );

  vec_wb_arbiter u_wb_arbiter (
    .clk, .reset,
    .madd_req, .madd_we, .madd_rt,
    .permute_req, .permute_we, .permute_rt,
    .madd_grant, .permute_grant,
    .wb_en, .wb_we, .wb_addr, .wb_unit
  );

  assign pipe_empty = !dec_busy && !head_valid && madd_empty && permute_empty && sb_idle;

endmodule

// ==== vec_wb_arbiter.sv ====
// rotating-mask arbiter that puts one finished unit per cycle onto the writeback port
`timescale 1ns/1ps

module vec_wb_arbiter import vec_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      madd_req,
  input  logic      madd_we,
  input  vec_reg_t  madd_rt,
  input  logic      permute_req,
  input  logic      permute_we,
  input  vec_reg_t  permute_rt,
  output logic      madd_grant,
  output logic      permute_grant,
  output logic      wb_en,
  output logic      wb_we,
  output vec_reg_t  wb_addr,
  output vec_unit_e wb_unit
);

  // indexed by unit id
  logic [1:0] mask;
  vec_unit_e  winner;
  logic       any_req;

  assign any_req = madd_req || permute_req;

  // ----------------------------------------
  // grant selection
  // ----------------------------------------
  always_comb begin
    if (madd_req && mask[unit_madd]) begin
      winner = unit_madd;
    end else if (permute_req && mask[unit_permute]) begin
      winner = unit_permute;
    end else if (madd_req) begin
      winner = unit_madd;
    end else begin
      winner = unit_permute;
    end
  end

  assign madd_grant    = madd_req && (winner == unit_madd);
  assign permute_grant = permute_req && (winner == unit_permute);
  assign wb_en         = any_req;
  assign wb_unit       = winner;
  assign wb_addr       = (winner == unit_madd) ? madd_rt : permute_rt;
  assign wb_we         = any_req && ((winner == unit_madd) ? madd_we : permute_we);

  // ----------------------------------------
  // mask rotation
  // ----------------------------------------
  // 11 -> 10 -> 00 -> 11, stepping once per requesting cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mask <= 2'b11;
    end else if (any_req) begin
      if (!mask[unit_permute]) begin
        mask <= 2'b11;
      end else if (mask[unit_madd]) begin
        mask[unit_madd] <= 1'b0;
      end else begin
        mask[unit_permute] <= 1'b0;
      end
    end
  end

  // rotation bounds the wait of a held request
  assert property (@(posedge clk) disable iff (reset)
      (madd_req && !madd_grant) |=> madd_grant)
    else $error("madd writeback request passed over twice");
  assert property (@(posedge clk) disable iff (reset)
      (permute_req && !permute_grant && $past(permute_req && !permute_grant))
      |=> permute_grant)
    else $error("permute writeback request starved");

endmodule

// ==== vec_unit_pipe.sv ====
// fixed-latency execution pipeline model that holds its finished head until writeback grant
`timescale 1ns/1ps

module vec_unit_pipe import vec_pkg::*; #(
  parameter int LATENCY = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     issue,
  input  vec_reg_t issue_rt,
  input  logic     issue_we,
  input  logic     grant,
  output logic     in_ready,
  output logic     req,
  output vec_reg_t req_rt,
  output logic     req_we,
  output logic     empty
);

  logic [LATENCY-1:0] valid_q;
  logic [LATENCY-1:0] we_q;
  vec_reg_t           rt_q [LATENCY];
  logic               advance;

  // whole pipe moves only when the last stage is free or leaving
  assign advance = !valid_q[LATENCY-1] || grant;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q[0] <= issue;
      for (int i = 1; i < LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // stage payload
  always_ff @(posedge clk) begin
    if (advance) begin
      rt_q[0] <= issue_rt;
      we_q[0] <= issue_we;
      for (int i = 1; i < LATENCY; i++) begin
        rt_q[i] <= rt_q[i-1];
        we_q[i] <= we_q[i-1];
      end
    end
  end

  assign in_ready = advance;
  assign req      = valid_q[LATENCY-1];
  assign req_rt   = rt_q[LATENCY-1];
  assign req_we   = we_q[LATENCY-1];
  assign empty    = (valid_q == '0);

  // an issue into a stalled pipe would be lost
  assert property (@(posedge clk) disable iff (reset) issue |-> in_ready)
    else $error("operation issued while pipe stalled");

endmodule

// ==== vec_scoreboard.sv ====
// pending-write scoreboard that checks the queue head for hazards and issues it to a unit
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_scoreboard import vec_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      head_valid,
  input  vec_unit_e head_unit,
  input  logic      head_read_ra,
  input  logic      head_read_rb,
  input  logic      head_write_rt,
  input  vec_reg_t  head_rt,
  input  vec_reg_t  head_ra,
  input  vec_reg_t  head_rb,
  input  logic      madd_in_ready,
  input  logic      permute_in_ready,
  input  logic      wb_en,
  input  logic      wb_we,
  input  vec_reg_t  wb_addr,
  output logic      pop,
  output logic      issue_madd,
  output logic      issue_permute,
  output logic      idle
);

  // one bit per register with a write in flight
  logic [`VEC_NUM_REGS-1:0] pending;
  logic                     hazard;
  logic                     unit_ready;

  // ----------------------------------------
  // hazard check and issue
  // ----------------------------------------
  // RAW on ra/rb, WAW on rt
  assign hazard = (head_read_ra && pending[head_ra])
               || (head_read_rb && pending[head_rb])
               || (head_write_rt && pending[head_rt]);

  assign unit_ready = (head_unit == unit_madd) ? madd_in_ready : permute_in_ready;

  assign pop           = head_valid && !hazard && unit_ready;
  assign issue_madd    = pop && (head_unit == unit_madd);
  assign issue_permute = pop && (head_unit == unit_permute);
  assign idle          = (pending == '0);

  // ----------------------------------------
  // pending bit tracking
  // ----------------------------------------
  // set and clear never hit the same register in one cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending <= '0;
    end else begin
      if (wb_en && wb_we) begin
        pending[wb_addr] <= 1'b0;
      end
      if (pop && head_write_rt) begin
        pending[head_rt] <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
      (wb_en && wb_we) |-> pending[wb_addr])
    else $error("writeback to register %0d without pending write", wb_addr);

endmodule

// ==== vec_op_decode.sv ====
// input register and opcode decode that feeds classified operations into the queue
`timescale 1ns/1ps

module vec_op_decode import vec_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        inst_valid,
  input  vec_opcode_e inst_opcode,
  input  vec_reg_t    inst_rt,
  input  vec_reg_t    inst_ra,
  input  vec_reg_t    inst_rb,
  input  logic        q_full,
  output logic        push,
  output vec_unit_e   op_unit,
  output logic        op_read_ra,
  output logic        op_read_rb,
  output logic        op_write_rt,
  output vec_reg_t    op_rt,
  output vec_reg_t    op_ra,
  output vec_reg_t    op_rb,
  output logic        busy
);

  logic        valid_q;
  vec_opcode_e opcode_q;
  vec_reg_t    rt_q;
  vec_reg_t    ra_q;
  vec_reg_t    rb_q;
  logic        load;

  // take a new instruction once the held one has left
  assign load = !valid_q || push;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      opcode_q <= inst_opcode;
      rt_q     <= inst_rt;
      ra_q     <= inst_ra;
      rb_q     <= inst_rb;
    end
  end

  // ----------------------------------------
  // opcode classification
  // ----------------------------------------
  always_comb begin
    op_unit     = unit_madd;
    op_read_ra  = 1'b0;
    op_read_rb  = 1'b0;
    op_write_rt = 1'b0;
    case (opcode_q)
      op_add, op_mul: begin
        op_read_ra  = 1'b1;
        op_read_rb  = 1'b1;
        op_write_rt = 1'b1;
      end
      op_mac: begin
        op_read_ra = 1'b1;
        op_read_rb = 1'b1;
      end
      op_splat: begin
        op_unit     = unit_permute;
        op_write_rt = 1'b1;
      end
      op_shift: begin
        op_unit     = unit_permute;
        op_read_ra  = 1'b1;
        op_write_rt = 1'b1;
      end
      op_sel: begin
        op_unit     = unit_permute;
        op_read_ra  = 1'b1;
        op_read_rb  = 1'b1;
        op_write_rt = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign push  = valid_q && !q_full;
  assign op_rt = rt_q;
  assign op_ra = ra_q;
  assign op_rb = rb_q;
  assign busy  = valid_q;

  // ready upstream must keep new work away while a full queue blocks the held one
  assert property (@(posedge clk) disable iff (reset)
      q_full |-> !(push || (valid_q && inst_valid)))
    else $error("instruction pushed or overrun while queue full");

endmodule

// ==== vec_op_queue.sv ====
// in-order FIFO of decoded vector operations between decode and the issue scoreboard
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_op_queue import vec_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      push,
  input  logic      pop,
  input  vec_unit_e in_unit,
  input  logic      in_read_ra,
  input  logic      in_read_rb,
  input  logic      in_write_rt,
  input  vec_reg_t  in_rt,
  input  vec_reg_t  in_ra,
  input  vec_reg_t  in_rb,
  output logic      head_valid,
  output logic      full,
  output logic      almost_full,
  output vec_unit_e head_unit,
  output logic      head_read_ra,
  output logic      head_read_rb,
  output logic      head_write_rt,
  output vec_reg_t  head_rt,
  output vec_reg_t  head_ra,
  output vec_reg_t  head_rb
);

  localparam int DEPTH = `VEC_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef struct packed {
    vec_unit_e unit;
    logic      read_ra;
    logic      read_rb;
    logic      write_rt;
    vec_reg_t  rt;
    vec_reg_t  ra;
    vec_reg_t  rb;
  } entry_t;

  entry_t           mem [DEPTH];
  entry_t           head;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ----------------------------------------
  // pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= '{in_unit, in_read_ra, in_read_rb, in_write_rt, in_rt, in_ra, in_rb};
    end
  end

  assign head          = mem[rd_ptr];
  assign head_valid    = (count != '0);
  assign full          = (count == CNT_W'(DEPTH));
  assign almost_full   = ((CNT_W'(DEPTH) - count) <= CNT_W'(`VEC_QUEUE_AF_LEVEL));
  assign head_unit     = head.unit;
  assign head_read_ra  = head.read_ra;
  assign head_read_rb  = head.read_rb;
  assign head_write_rt = head.write_rt;
  assign head_rt       = head.rt;
  assign head_ra       = head.ra;
  assign head_rb       = head.rb;

  // producer and consumer respect the flags
  assert property (@(posedge clk) disable iff (reset) pop |-> head_valid)
    else $error("queue popped while empty");
  assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else $error("queue pushed while full");

endmodule

// ==== vec_pkg.sv ====
// shared types of the vector issue controller, imported by every RTL module and the testbench
`include "vec_defines.svh"

package vec_pkg;

  // vector register number
  typedef logic [$clog2(`VEC_NUM_REGS)-1:0] vec_reg_t;

  // instruction opcodes
  typedef enum logic [2:0] {
    op_add   = 3'd0,
    op_mul   = 3'd1,
    // accumulates inside the unit, no register write
    op_mac   = 3'd2,
    op_splat = 3'd3,
    op_shift = 3'd4,
    op_sel   = 3'd5
  } vec_opcode_e;

  // execution units, also the writeback source id
  typedef enum logic {
    unit_madd    = 1'b0,
    unit_permute = 1'b1
  } vec_unit_e;

endpackage

// ==== vec_defines.svh ====
// sizing and latency macros for the vector issue controller, included by RTL and testbench
`ifndef VEC_DEFINES_SVH
`define VEC_DEFINES_SVH

// ----------------------------------------
// register file
// ----------------------------------------
`define VEC_NUM_REGS 32

// ----------------------------------------
// operation queue
// ----------------------------------------
`define VEC_QUEUE_DEPTH 4
// ready drops at this many free slots or fewer
`define VEC_QUEUE_AF_LEVEL 2

// ----------------------------------------
// execution unit pipeline depths
// ----------------------------------------
`define VEC_MADD_LATENCY 3
`define VEC_PERMUTE_LATENCY 1

`endif
